// File: testbench/decode_cases.txt
# w addr data  (register write, hex)
# i instr pc alu_op src2_sel dest reg_write taken target  (alu_op, src2_sel as enum values)
w 01 00000010
w 02 00000010
w 03 fffffff0
w 04 00001234
w 05 00400200
i 00223020 00400000 1 0 6 1 0 00000000
i 00643823 00400004 2 0 7 1 0 00000000
i 0023402a 00400008 3 0 8 1 0 00000000
i 0061482b 0040000c 4 0 9 1 0 00000000
i 00245024 00400010 5 0 10 1 0 00000000
i 00445825 00400014 6 0 11 1 0 00000000
i 00646026 00400018 7 0 12 1 0 00000000
i 00226827 0040001c 8 0 13 1 0 00000000
i 000470c0 00400020 9 0 14 1 0 00000000
i 00037902 00400024 10 0 15 1 0 00000000
i 00038043 00400028 11 0 16 1 0 00000000
w 00 deadbeef
i 00018820 0040002c 1 0 17 1 0 00000000
i 2432fff0 00400030 1 1 18 1 0 00000000
i 28730005 00400034 3 1 19 1 0 00000000
i 2c340020 00400038 4 1 20 1 0 00000000
i 309500ff 0040003c 5 2 21 1 0 00000000
i 34368000 00400040 6 2 22 1 0 00000000
i 38570f0f 00400044 7 2 23 1 0 00000000
i 3c18abcd 00400048 12 2 24 1 0 00000000
i 8c250004 0040004c 0 0 0 0 0 00000000
i 00220018 00400050 0 0 0 0 0 00000000
i 10220010 00400100 0 0 0 0 1 00400144
i 10230010 00400200 0 0 0 0 0 00000000
i 1423fffe 00400300 0 0 0 0 1 004002fc
i 14220004 00400400 0 0 0 0 0 00000000
i 08100040 10000ffc 0 0 0 0 1 10400100
i 0c000200 2ffffffc 1 3 31 1 1 30000800
i 00a00008 00400600 0 0 0 0 1 00400200

// File: filelist.f
+incdir+source
source/decode_pkg.sv
source/register_file.sv
source/branch_unit.sv
source/decode_stage.sv
source/operand_stage.sv
source/decode_top.sv
testbench/decode_chk.sv
testbench/decode_clock.sv
testbench/decode_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = decode_tb
FILELIST = filelist.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(TOOL), run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "^test passed$$" $(LOG); then \
		echo "Simulation result: PASS"; \
	else \
		echo "Simulation result: FAIL, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: testbench/decode_tb.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module decode_tb;
  import decode_pkg::*;

  localparam string CASE_FILE       = "testbench/decode_cases.txt";
  localparam int    CYCLES_PER_LINE = 200;

  typedef struct packed {
    data_t     instruction;
    data_t     pc;
    data_t     rs_value;
    data_t     rt_value;
    alu_op_e   alu_op;
    src2_sel_e src2_sel;
    reg_addr_t dest;
    logic      reg_write;
    logic      taken;
    data_t     target;
  } expect_t;

  logic        clock;
  logic        reset;
  fetch_word_t in_word;
  logic        in_valid;
  logic        in_ready;
  issue_bus_t  out_issue;
  logic        out_valid;
  logic        out_ready;
  redirect_t   redirect;
  rf_write_t   rf_write;

  data_t   reg_model [`DECODE_REG_COUNT];
  expect_t pending [$];
  int      case_lines = 0;
  int      sent_count = 0;
  int      received_count = 0;
  int      in_flight = 0;
  int      error_count = 0;
  int      item_errors = 0;

  decode_clock decode_clock_inst (
    .clock (clock),
    .reset (reset)
  );

  decode_top decode_top_inst (
    .clock     (clock),
    .reset     (reset),
    .in_word   (in_word),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .out_issue (out_issue),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .redirect  (redirect),
    .rf_write  (rf_write)
  );

  // ****************************************
  // Helpers
  // ****************************************

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s actual %h expected %h", $time, name, actual, expected);
      error_count++;
      item_errors++;
    end
  endtask

  function automatic int count_case_lines(input int fd);
    string line;
    int    lines;
    lines = 0;
    while ($fgets(line, fd) != 0) begin
      if (line.len() > 0 && (line.getc(0) == "w" || line.getc(0) == "i")) begin
        lines++;
      end
    end
    return lines;
  endfunction

  task automatic check_after_reset();
    item_errors = 0;
    check_value("out_valid", 32'(out_valid), 32'd0);
    check_value("redirect.valid", 32'(redirect.valid), 32'd0);
    check_value("in_ready", 32'(in_ready), 32'd1);
    $display("reset check: %s", (item_errors == 0) ? "ok" : "MISMATCH");
  endtask

  // Writes go in only while the pipeline is empty, so the model stays exact.
  task automatic write_register(input reg_addr_t addr, input data_t data);
    while (received_count != sent_count) @(negedge clock);
    rf_write = '{enable: 1'b1, addr: addr, data: data};
    @(negedge clock);
    rf_write = '0;
    if (addr != '0) begin
      reg_model[addr] = data;
    end
  endtask

  task automatic send_instruction(input expect_t exp);
    pending.push_back(exp);
    sent_count++;
    in_word  = '{instruction: exp.instruction, pc: exp.pc};
    in_valid = 1'b1;
    @(posedge clock);
    while (!in_ready) @(posedge clock);
    @(negedge clock);
    in_valid = 1'b0;
  endtask

  task automatic compare_output();
    expect_t   exp;
    alu_op_e   op;
    src2_sel_e sel;
    logic      shift_op;
    logic      link_op;
    item_errors = 0;
    if (pending.size() == 0) begin
      $display("An instruction came out at %0t that was never sent.", $time);
      error_count++;
    end else begin
      exp = pending.pop_front();
      op  = exp.alu_op;
      sel = exp.src2_sel;
      // Shifts take shamt as source 1, and jal takes the pc.
      shift_op = (exp.instruction[31:26] == 6'h00) &&
                 (exp.instruction[5:0] inside {6'h00, 6'h02, 6'h03});
      link_op  = (exp.instruction[31:26] == 6'h03);
      check_value("out_issue.pc", out_issue.pc, exp.pc);
      check_value("out_issue.rs_value", out_issue.rs_value, exp.rs_value);
      check_value("out_issue.rt_value", out_issue.rt_value, exp.rt_value);
      check_value("out_issue.immediate", 32'(out_issue.immediate),
                  32'(exp.instruction[15:0]));
      check_value("out_issue.shamt", 32'(out_issue.shamt), 32'(exp.instruction[10:6]));
      check_value("out_issue.alu_op", 32'(out_issue.alu_op), 32'(exp.alu_op));
      check_value("out_issue.src2_sel", 32'(out_issue.src2_sel), 32'(exp.src2_sel));
      check_value("out_issue.src1_is_shamt", 32'(out_issue.src1_is_shamt), 32'(shift_op));
      check_value("out_issue.src1_is_pc", 32'(out_issue.src1_is_pc), 32'(link_op));
      check_value("out_issue.reg_write", 32'(out_issue.reg_write), 32'(exp.reg_write));
      if (exp.reg_write) begin
        check_value("out_issue.dest", 32'(out_issue.dest), 32'(exp.dest));
      end
      check_value("redirect.valid", 32'(redirect.valid), 32'(exp.taken));
      if (exp.taken) begin
        check_value("redirect.target", redirect.target, exp.target);
      end
      received_count++;
      $display("instruction %0d pc %h %s %s: %s", received_count, exp.pc, op.name(),
               sel.name(), (item_errors == 0) ? "ok" : "MISMATCH");
    end
  endtask

  // ****************************************
  // Stimulus
  // ****************************************

  initial begin
    void'($urandom(17715));
    out_ready = 1'b0;
    forever begin
      @(negedge clock);
      out_ready = ($urandom % 4) != 0; // Stall about one cycle in four.
    end
  end

  initial begin
    int          fd;
    int          fields;
    string       line;
    byte         kind;
    logic [31:0] addr;
    logic [31:0] data;
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] target;
    int          alu;
    int          src2;
    int          dest;
    int          wr;
    int          taken;
    expect_t     exp;

    in_word  = '0;
    in_valid = 1'b0;
    rf_write = '0;
    for (int i = 0; i < `DECODE_REG_COUNT; i++) begin
      reg_model[i] = '0;
    end

    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open %s, no cases were run.", CASE_FILE);
      error_count++;
    end else begin
      case_lines = count_case_lines(fd);
      $fclose(fd);
      fd = $fopen(CASE_FILE, "r");
      @(negedge clock);
      while (reset) @(negedge clock);
      check_after_reset();
      while ($fgets(line, fd) != 0) begin
        kind = (line.len() > 0) ? line.getc(0) : 8'h00;
        if (kind == "w") begin
          fields = $sscanf(line, "w %h %h", addr, data);
          if (fields == 2) begin
            write_register(addr[4:0], data);
          end else begin
            $display("A register write line has the wrong number of fields: %s", line);
            error_count++;
          end
        end else if (kind == "i") begin
          fields = $sscanf(line, "i %h %h %d %d %d %d %d %h",
                           instr, pc, alu, src2, dest, wr, taken, target);
          if (fields == 8) begin
            exp.instruction = instr;
            exp.pc          = pc;
            exp.rs_value    = reg_model[instr[25:21]];
            exp.rt_value    = reg_model[instr[20:16]];
            exp.alu_op      = alu_op_e'(alu[3:0]);
            exp.src2_sel    = src2_sel_e'(src2[1:0]);
            exp.dest        = dest[4:0];
            exp.reg_write   = wr[0];
            exp.taken       = taken[0];
            exp.target      = target;
            send_instruction(exp);
          end else begin
            $display("An instruction line has the wrong number of fields: %s", line);
            error_count++;
          end
        end
      end
      $fclose(fd);
      while (received_count != sent_count) @(negedge clock);
      repeat (4) @(negedge clock);
    end

    $display("Summary: %0d of %0d instructions checked, %0d errors.",
             received_count, sent_count, error_count);
    if (error_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // ****************************************
  // Output monitor and watchdog
  // ****************************************

  always @(posedge clock) begin
    if (!reset) begin
      // Both slots full and a stalled output is the only reason to refuse input.
      check_value("in_ready", 32'(in_ready), 32'(!(in_flight == 2 && !out_ready)));
      if (in_valid && in_ready) begin
        in_flight++;
      end
      if (out_valid && out_ready) begin
        compare_output();
        in_flight--;
      end
    end
  end

  initial begin
    wait (case_lines > 0);
    repeat (case_lines * CYCLES_PER_LINE) @(posedge clock);
    $display("Timeout: only %0d of %0d instructions came out in time.",
             received_count, sent_count);
    $display("test failed");
    $finish;
  end

endmodule

// File: testbench/decode_clock.sv
`timescale 1ns/1ns

module decode_clock (
  output logic clock,
  output logic reset
);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock; // 8 ns period.
  end

  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clock);
    reset <= 1'b0;
  end

endmodule

// File: testbench/decode_chk.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module decode_chk (
  input logic                    clock,
  input logic                    reset,
  input decode_pkg::fetch_word_t in_word,
  input logic                    in_valid,
  input logic                    in_ready,
  input decode_pkg::issue_bus_t  out_issue,
  input logic                    out_valid,
  input logic                    out_ready,
  input decode_pkg::redirect_t   redirect
);
  import decode_pkg::*;

  // Operand values may change during a stall when a write lands, the rest may not.
  out_hold: assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> out_valid &&
      $stable({out_issue.pc, out_issue.immediate, out_issue.shamt, out_issue.dest,
               out_issue.reg_write, out_issue.alu_op, out_issue.src2_sel,
               out_issue.src1_is_shamt, out_issue.src1_is_pc}))
    else $error("out_issue changed or out_valid dropped while stalled");

  in_hold: assert property (@(posedge clock) disable iff (reset)
    in_valid && !in_ready |=> in_valid && $stable(in_word))
    else $error("in_word changed or in_valid dropped while stalled");

  // Of the taken branches and jumps only jal writes, and it links through pc + 8.
  redirect_link: assert property (@(posedge clock) disable iff (reset)
    redirect.valid && out_issue.reg_write |->
      out_issue.dest == reg_addr_t'(`DECODE_LINK_REG) && out_issue.src1_is_pc &&
      out_issue.src2_sel == src2_eight)
    else $error("redirect with a register write that is not a jal link");

  ready_after_reset: assert property (@(posedge clock) reset |=> in_ready)
    else $error("in_ready low in the cycle after reset");

endmodule

bind decode_top decode_chk decode_chk_inst (
  .clock     (clock),
  .reset     (reset),
  .in_word   (in_word),
  .in_valid  (in_valid),
  .in_ready  (in_ready),
  .out_issue (out_issue),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .redirect  (redirect)
);

// File: source/decode_top.sv
`timescale 1ns/1ns

module decode_top (
  input  logic                    clock,
  input  logic                    reset,
  input  decode_pkg::fetch_word_t in_word,
  input  logic                    in_valid,
  output logic                    in_ready,
  output decode_pkg::issue_bus_t  out_issue,
  output logic                    out_valid,
  input  logic                    out_ready,
  output decode_pkg::redirect_t   redirect,
  input  decode_pkg::rf_write_t   rf_write
);
  import decode_pkg::*;

  decoded_t  mid_item;
  logic      mid_valid;
  logic      mid_ready;
  reg_addr_t rs_addr;
  reg_addr_t rt_addr;
  data_t     rs_data;
  data_t     rt_data;

  decode_stage decode_stage_inst (
    .clock     (clock),
    .reset     (reset),
    .in_word   (in_word),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .mid_item  (mid_item),
    .mid_valid (mid_valid),
    .mid_ready (mid_ready)
  );

  operand_stage operand_stage_inst (
    .clock     (clock),
    .reset     (reset),
    .mid_item  (mid_item),
    .mid_valid (mid_valid),
    .mid_ready (mid_ready),
    .rs_addr   (rs_addr),
    .rt_addr   (rt_addr),
    .rs_data   (rs_data),
    .rt_data   (rt_data),
    .out_issue (out_issue),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .redirect  (redirect)
  );

  register_file register_file_inst (
    .clock    (clock),
    .reset    (reset),
    .rs_addr  (rs_addr),
    .rt_addr  (rt_addr),
    .rs_data  (rs_data),
    .rt_data  (rt_data),
    .rf_write (rf_write)
  );

endmodule

// File: source/operand_stage.sv
`timescale 1ns/1ns

module operand_stage (
  input  logic                   clock,
  input  logic                   reset,
  input  decode_pkg::decoded_t   mid_item,
  input  logic                   mid_valid,
  output logic                   mid_ready,
  output decode_pkg::reg_addr_t  rs_addr,
  output decode_pkg::reg_addr_t  rt_addr,
  input  decode_pkg::data_t      rs_data,
  input  decode_pkg::data_t      rt_data,
  output decode_pkg::issue_bus_t out_issue,
  output logic                   out_valid,
  input  logic                   out_ready,
  output decode_pkg::redirect_t  redirect
);
  import decode_pkg::*;

  decoded_t item;
  logic     taken;
  data_t    target;

  assign mid_ready = !out_valid || out_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (mid_ready) begin
      out_valid <= mid_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (mid_valid && mid_ready) begin
      item <= mid_item;
    end
  end

  // Read every cycle so that a write landing during a stall is seen.
  assign rs_addr = item.rs;
  assign rt_addr = item.rt;

  assign out_issue = '{
    pc:            item.pc,
    rs_value:      rs_data,
    rt_value:      rt_data,
    immediate:     item.immediate,
    shamt:         item.shamt,
    dest:          item.dest,
    reg_write:     item.reg_write,
    alu_op:        item.alu_op,
    src2_sel:      item.src2_sel,
    src1_is_shamt: item.src1_is_shamt,
    src1_is_pc:    item.src1_is_pc
  };

  branch_unit branch_unit_inst (
    .kind       (item.branch_kind),
    .pc         (item.pc),
    .immediate  (item.immediate),
    .jump_index (item.jump_index),
    .rs_value   (rs_data),
    .rt_value   (rt_data),
    .taken      (taken),
    .target     (target)
  );

  assign redirect.valid  = out_valid && out_ready && taken; // Only on the leaving cycle.
  assign redirect.target = target;

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module decode_stage (
  input  logic                    clock,
  input  logic                    reset,
  input  decode_pkg::fetch_word_t in_word,
  input  logic                    in_valid,
  output logic                    in_ready,
  output decode_pkg::decoded_t    mid_item,
  output logic                    mid_valid,
  input  logic                    mid_ready
);
  import decode_pkg::*;

  fetch_word_t  word;
  opcode_e      opcode;
  funct_e       funct;
  reg_addr_t    rs;
  reg_addr_t    rt;
  reg_addr_t    rd;
  logic [4:0]   shamt;
  alu_op_e      alu_op;
  src2_sel_e    src2_sel;
  branch_kind_e branch_kind;
  logic         src1_is_shamt;
  logic         write_rd;
  logic         write_rt;
  logic         write_link;

  assign in_ready = !mid_valid || mid_ready; // Empty, or the held item leaves now.

  always_ff @(posedge clock) begin
    if (reset) begin
      mid_valid <= 1'b0;
    end else if (in_ready) begin
      mid_valid <= in_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid && in_ready) begin
      word <= in_word;
    end
  end

  // ****************************************
  // Field split and decode
  // ****************************************

  assign opcode = opcode_e'(word.instruction[31:26]);
  assign rs     = word.instruction[25:21];
  assign rt     = word.instruction[20:16];
  assign rd     = word.instruction[15:11];
  assign shamt  = word.instruction[10:6];
  assign funct  = funct_e'(word.instruction[5:0]);

  always_comb begin
    alu_op        = alu_none;
    src2_sel      = src2_reg;
    branch_kind   = branch_none;
    src1_is_shamt = 1'b0;
    write_rd      = 1'b0;
    write_rt      = 1'b0;
    write_link    = 1'b0;
    case (opcode)
      op_special: begin
        case (funct)
          funct_add, funct_addu: alu_op = alu_add;
          funct_sub, funct_subu: alu_op = alu_sub;
          funct_slt:  alu_op = alu_slt;
          funct_sltu: alu_op = alu_sltu;
          funct_and:  alu_op = alu_and;
          funct_or:   alu_op = alu_or;
          funct_xor:  alu_op = alu_xor;
          funct_nor:  alu_op = alu_nor;
          funct_sll:  alu_op = alu_sll;
          funct_srl:  alu_op = alu_srl;
          funct_sra:  alu_op = alu_sra;
          funct_jr:   branch_kind = branch_jr;
          default:    alu_op = alu_none;
        endcase
        src1_is_shamt = (alu_op == alu_sll) || (alu_op == alu_srl) || (alu_op == alu_sra);
        write_rd = (alu_op != alu_none); // jr and unknown functions write nothing.
      end
      op_addiu: begin
        alu_op   = alu_add;
        src2_sel = src2_simm;
        write_rt = 1'b1;
      end
      op_slti: begin
        alu_op   = alu_slt;
        src2_sel = src2_simm;
        write_rt = 1'b1;
      end
      op_sltiu: begin
        alu_op   = alu_sltu;
        src2_sel = src2_simm;
        write_rt = 1'b1;
      end
      op_andi: begin
        alu_op   = alu_and;
        src2_sel = src2_zimm;
        write_rt = 1'b1;
      end
      op_ori: begin
        alu_op   = alu_or;
        src2_sel = src2_zimm;
        write_rt = 1'b1;
      end
      op_xori: begin
        alu_op   = alu_xor;
        src2_sel = src2_zimm;
        write_rt = 1'b1;
      end
      op_lui: begin
        alu_op   = alu_lui;
        src2_sel = src2_zimm;
        write_rt = 1'b1;
      end
      op_beq: branch_kind = branch_beq;
      op_bne: branch_kind = branch_bne;
      op_j:   branch_kind = branch_jump;
      op_jal: begin
        // The link value is pc + 8, formed in execute from pc and the constant.
        alu_op      = alu_add;
        src2_sel    = src2_eight;
        branch_kind = branch_jump;
        write_link  = 1'b1;
      end
      default: alu_op = alu_none;
    endcase
  end

  assign mid_item = '{
    pc:            word.pc,
    rs:            rs,
    rt:            rt,
    dest:          write_link ? reg_addr_t'(`DECODE_LINK_REG) : (write_rt ? rt : rd),
    immediate:     word.instruction[15:0],
    jump_index:    word.instruction[25:0],
    alu_op:        alu_op,
    src2_sel:      src2_sel,
    src1_is_shamt: src1_is_shamt,
    shamt:         shamt,
    src1_is_pc:    write_link,
    reg_write:     write_rd || write_rt || write_link,
    branch_kind:   branch_kind
  };

endmodule

// File: source/branch_unit.sv
`timescale 1ns/1ns

module branch_unit (
  input  decode_pkg::branch_kind_e kind,
  input  decode_pkg::data_t        pc,
  input  logic [15:0]              immediate,
  input  logic [25:0]              jump_index,
  input  decode_pkg::data_t        rs_value,
  input  decode_pkg::data_t        rt_value,
  output logic                     taken,
  output decode_pkg::data_t        target
);
  import decode_pkg::*;

  data_t pc_next;
  data_t offset;

  assign pc_next = pc + data_t'(4); // Address of the delay slot.
  assign offset  = {{14{immediate[15]}}, immediate, 2'b00};

  always_comb begin
    taken  = 1'b0;
    target = pc_next + offset;
    case (kind)
      branch_beq: taken = (rs_value == rt_value);
      branch_bne: taken = (rs_value != rt_value);
      branch_jump: begin
        taken  = 1'b1;
        target = {pc_next[31:28], jump_index, 2'b00}; // Stays in the current 256 MB region.
      end
      branch_jr: begin
        taken  = 1'b1;
        target = rs_value;
      end
      default: taken = 1'b0;
    endcase
  end

endmodule

// File: source/register_file.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module register_file (
  input  logic                  clock,
  input  logic                  reset,
  input  decode_pkg::reg_addr_t rs_addr,
  input  decode_pkg::reg_addr_t rt_addr,
  output decode_pkg::data_t     rs_data,
  output decode_pkg::data_t     rt_data,
  input  decode_pkg::rf_write_t rf_write
);
  import decode_pkg::*;

  data_t regs [`DECODE_REG_COUNT];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `DECODE_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (rf_write.enable && (rf_write.addr != '0)) begin
      regs[rf_write.addr] <= rf_write.data;
    end
  end

  // No bypass, a read sees only writes from earlier edges.
  assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
  assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

// File: source/decode_pkg.sv
`include "decode_config.svh"

package decode_pkg;

  typedef logic [`DECODE_DATA_WIDTH-1:0] data_t;
  typedef logic [`DECODE_REG_ADDR_WIDTH-1:0] reg_addr_t;

  // ****************************************
  // Encodings
  // ****************************************

  typedef enum logic [5:0] {
    op_special = 6'h00,
    op_j       = 6'h02,
    op_jal     = 6'h03,
    op_beq     = 6'h04,
    op_bne     = 6'h05,
    op_addiu   = 6'h09,
    op_slti    = 6'h0a,
    op_sltiu   = 6'h0b,
    op_andi    = 6'h0c,
    op_ori     = 6'h0d,
    op_xori    = 6'h0e,
    op_lui     = 6'h0f
  } opcode_e;

  typedef enum logic [5:0] {
    funct_sll  = 6'h00,
    funct_srl  = 6'h02,
    funct_sra  = 6'h03,
    funct_jr   = 6'h08,
    funct_add  = 6'h20,
    funct_addu = 6'h21,
    funct_sub  = 6'h22,
    funct_subu = 6'h23,
    funct_and  = 6'h24,
    funct_or   = 6'h25,
    funct_xor  = 6'h26,
    funct_nor  = 6'h27,
    funct_slt  = 6'h2a,
    funct_sltu = 6'h2b
  } funct_e;

  typedef enum logic [3:0] {
    alu_none, alu_add, alu_sub, alu_slt, alu_sltu, alu_and, alu_or,
    alu_xor, alu_nor, alu_sll, alu_srl, alu_sra, alu_lui
  } alu_op_e;

  typedef enum logic [1:0] {
    src2_reg, src2_simm, src2_zimm, src2_eight
  } src2_sel_e;

  typedef enum logic [2:0] {
    branch_none, branch_beq, branch_bne, branch_jump, branch_jr
  } branch_kind_e;

  // ****************************************
  // Buses
  // ****************************************

  typedef struct packed {
    data_t instruction;
    data_t pc;
  } fetch_word_t;

  typedef struct packed {
    data_t        pc;
    reg_addr_t    rs;
    reg_addr_t    rt;
    reg_addr_t    dest;
    logic [15:0]  immediate;
    logic [25:0]  jump_index;
    alu_op_e      alu_op;
    src2_sel_e    src2_sel;
    logic         src1_is_shamt;
    logic [4:0]   shamt;
    logic         src1_is_pc;
    logic         reg_write;
    branch_kind_e branch_kind;
  } decoded_t;

  typedef struct packed {
    data_t       pc;
    data_t       rs_value;
    data_t       rt_value;
    logic [15:0] immediate;
    logic [4:0]  shamt;
    reg_addr_t   dest;
    logic        reg_write;
    alu_op_e     alu_op;
    src2_sel_e   src2_sel;
    logic        src1_is_shamt;
    logic        src1_is_pc;
  } issue_bus_t;

  typedef struct packed {
    logic  valid;
    data_t target;
  } redirect_t;

  typedef struct packed {
    logic      enable;
    reg_addr_t addr;
    data_t     data;
  } rf_write_t;

endpackage

// File: source/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// ****************************************
// Core sizes
// ****************************************

// Width of a register and of the program count.
`define DECODE_DATA_WIDTH 32

// Number of architectural registers and the width of an index.
`define DECODE_REG_COUNT 32
`define DECODE_REG_ADDR_WIDTH 5

// Register written by jal.
`define DECODE_LINK_REG 31

`endif
